// File: uart_cpu_board.f
rtl/board_pkg.sv
rtl/isa_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/insn_loader.sv
rtl/prog_mem.sv
rtl/cpu_core.sv
rtl/led_scan.sv
rtl/board_top.sv
test/tb_clock.sv
test/board_top_asserts.sv
test/tb_board_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_board_top
RTL_TOP    = board_top
FILELIST   = uart_cpu_board.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_board_top.sv
module tb_board_top import board_pkg::*, isa_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int N_ENTRIES  = 4;
  localparam int MAX_WORDS  = 12;
  localparam int MAX_OUT    = 8;

  logic       sys_clk;
  logic       rst_n;
  logic       uart_rx;
  logic       uart_tx;
  byte_t      led_col;
  logic [8:0] led_row;

  insn_t  prog_tab [N_ENTRIES][MAX_WORDS];  // program words, terminator added on send
  int     prog_len [N_ENTRIES];
  byte_t  exp_tab  [N_ENTRIES][MAX_OUT];    // bytes expected back on uart_tx
  int     exp_len  [N_ENTRIES];
  byte_t  last_reg0;   // accumulator left by the final program
  byte_t  rx_q [$];    // decoded uart_tx bytes
  int     seed;
  int     n_checks;
  int     n_errors;
  longint wd_time;

  tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.sys_clk(sys_clk));

  board_top DUT (.*);

  bind board_top board_top_asserts u_asserts (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n_sync),
    .led_row    (led_row),
    .tx_en      (tx_en),
    .tx_busy    (tx_busy),
    .mem_wr     (mem_wr),
    .prog_ready (prog_ready),
    .uart_tx    (uart_tx)
  );

  task automatic add_insn(input int t, input opcode_e op, input byte_t imm);
    prog_tab[t][prog_len[t]] = {op, 4'h0, imm};  // bits 11:8 unused
    prog_len[t]++;
  endtask

  task automatic add_expect(input int t, input byte_t b);
    exp_tab[t][exp_len[t]] = b;
    exp_len[t]++;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic build_table();
    byte_t r0, r1, r2;
    byte_t a, b;
    int    n;
    // 250 + 10 wraps to 4, then 4 - 20 wraps to 240
    add_insn(0, LDI, 8'd250);
    add_insn(0, OUT, 8'h00);
    add_insn(0, ADDI, 8'd10);
    add_insn(0, OUT, 8'h00);
    add_insn(0, SUBI, 8'd20);
    add_insn(0, OUT, 8'h00);
    add_insn(0, HALT, 8'h00);
    add_expect(0, 8'd250);
    add_expect(0, 8'd4);
    add_expect(0, 8'd240);
    // countdown loop back to address 1
    add_insn(1, LDI, 8'd3);
    add_insn(1, OUT, 8'h00);
    add_insn(1, SUBI, 8'd1);
    add_insn(1, JNZ, 8'd1);
    add_insn(1, HALT, 8'h00);
    for (n = 3; n > 0; n--) add_expect(1, byte_t'(n));
    // random immediates with OUTs stacked behind a busy transmitter
    r0 = byte_t'($random(seed));
    r1 = byte_t'($random(seed));
    r2 = byte_t'($random(seed));
    a  = r0 + r1;  // mod 256
    b  = a - r2;
    add_insn(2, LDI, r0);
    add_insn(2, OUT, 8'h00);
    add_insn(2, OUT, 8'h00);
    add_insn(2, ADDI, r1);
    add_insn(2, OUT, 8'h00);
    add_insn(2, SUBI, r2);
    add_insn(2, OUT, 8'h00);
    add_insn(2, OUT, 8'h00);
    add_insn(2, HALT, 8'h00);
    add_expect(2, r0);
    add_expect(2, r0);
    add_expect(2, a);
    add_expect(2, b);
    add_expect(2, b);
    // reload shorter than program 2 so stale words sit past the HALT
    add_insn(3, LDI, 8'h81);
    add_insn(3, JMP, 8'd3);
    add_insn(3, OUT, 8'h00);  // skipped by the jump
    add_insn(3, ADDI, 8'd1);
    add_insn(3, OUT, 8'h00);
    add_insn(3, HALT, 8'h00);
    add_expect(3, 8'h82);
    last_reg0 = 8'h82;
  endtask

  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};  // start bit goes out first
    for (i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      #2 uart_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
    end
  endtask

  task automatic load_program(input int t);
    insn_t word;
    int    i;
    for (i = 0; i <= prog_len[t]; i++) begin
      word = (i == prog_len[t]) ? TERM_WORD : prog_tab[t][i];
      send_byte(word[15:8]);  // high byte first
      send_byte(word[7:0]);
    end
  endtask

  function automatic byte_t expected_col(input int row);
    case (row)
      0:       return 8'b10101010;        // fixed marker
      1:       return last_reg0;
      2:       return TERM_WORD[15:8];    // last word in is the terminator
      3:       return TERM_WORD[7:0];
      default: return 8'h00;
    endcase
  endfunction

  task automatic check_led_scan();
    int         p, row, cnt;
    int         bad [8];
    int         lit [8];
    logic [8:0] exp_row;
    // first lit cycle of row 0
    while (led_row[0] !== 1'b0) @(negedge sys_clk);
    while (led_row[0] !== 1'b1) @(negedge sys_clk);
    for (p = ROW_GAP; p < ROW_GAP + 8 * ROW_PERIOD; p++) begin
      row     = (p / ROW_PERIOD) % 8;
      cnt     = p % ROW_PERIOD;
      exp_row = (cnt >= ROW_GAP && cnt < ROW_PERIOD - ROW_GAP) ? 9'b1 << row : 9'b0;
      if (led_row !== exp_row) bad[row]++;
      if (led_row[row]) lit[row]++;
      if (cnt == ROW_PERIOD / 2)
        check_value(led_col, expected_col(row), $sformatf("led_col in row %0d", row));
      @(negedge sys_clk);
    end
    for (row = 0; row < 8; row++) begin
      check_value(bad[row], 0, $sformatf("led_row cycles off pattern in row %0d", row));
      check_value(lit[row], ROW_PERIOD - 2 * ROW_GAP, $sformatf("lit cycles of row %0d", row));
    end
  endtask

  // uart_tx frames sampled mid bit on the falling clock
  initial begin : rx_decode
    byte_t b;
    int    i;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
      for (i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        b[i] = uart_tx;  // lsb first
      end
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      check_value(uart_tx, 1'b1, "stop bit of uart_tx frame");
      rx_q.push_back(b);
    end
  end

  initial begin : watchdog
    wait (wd_time > 0);
    #(wd_time);
    $display("timeout after %0d time units, the DUT stopped responding", wd_time);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    int t;
    int i;
    int n_bytes;
    seed     = 67;
    n_checks = 0;
    n_errors = 0;
    wd_time  = 0;
    rst_n    = 1'b0;
    uart_rx  = 1'b1;  // line idle
    build_table();
    n_bytes = 0;
    for (t = 0; t < N_ENTRIES; t++) n_bytes += 2 * (prog_len[t] + 1) + exp_len[t];
    // 10 bits per byte, one led scan, one more scan to find row 0, then slack
    wd_time = longint'(n_bytes) * 10 * CLKS_PER_BIT * CLK_PERIOD
            + 2 * 8 * ROW_PERIOD * CLK_PERIOD + 100000;
    repeat (4) @(posedge sys_clk);
    #2 rst_n = 1'b1;
    repeat (4) @(posedge sys_clk);  // synchronizer release
    for (t = 0; t < N_ENTRIES; t++) begin
      load_program(t);
      while (rx_q.size() < exp_len[t]) @(negedge sys_clk);
      for (i = 0; i < exp_len[t]; i++)
        check_value(rx_q.pop_front(), exp_tab[t][i], $sformatf("program %0d byte %0d", t, i));
    end
    check_led_scan();
    check_value(rx_q.size(), 0, "extra bytes on uart_tx");  // stale words past the HALT
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  end

endmodule

// File: test/board_top_asserts.sv
module board_top_asserts import isa_pkg::*; (
  input logic       sys_clk,
  input logic       rst_n,
  input logic [8:0] led_row,
  input logic       tx_en,
  input logic       tx_busy,
  input mem_wr_t    mem_wr,
  input logic       prog_ready,
  input logic       uart_tx
);

  // never two rows driven together
  led_row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(led_row))
    else $error("led_row has more than one row lit");

  // cpu waits for the transmitter
  tx_en_not_busy: assert property (@(posedge sys_clk) disable iff (!rst_n) tx_en |-> !tx_busy)
    else $error("tx_en pulsed while tx_busy was high");

  // program ram frozen while the cpu runs
  no_write_running: assert property (@(posedge sys_clk) disable iff (!rst_n)
    mem_wr.en |-> !prog_ready)
    else $error("program memory written while prog_ready was high");

  tx_idle_high: assert property (@(posedge sys_clk) disable iff (!rst_n) !tx_busy |-> uart_tx)
    else $error("uart_tx low while the transmitter is idle");  // idle mark

endmodule

// File: test/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic sys_clk
);

  initial sys_clk = 1'b0;

  always #(PERIOD / 2) sys_clk = ~sys_clk;  // even duty

endmodule

// File: rtl/board_top.sv
module board_top import board_pkg::*, isa_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,    // raw, from the button
  input  logic       uart_rx,
  output logic       uart_tx,
  output byte_t      led_col,
  output logic [8:0] led_row
);

  logic [1:0] rst_sync;
  logic       rst_n_sync;  // async assert, sync release

  byte_t   rx_data;
  logic    rx_wr;
  mem_wr_t mem_wr;
  logic    prog_ready;
  insn_t   recv_word;
  pc_t     pc;
  insn_t   insn;
  byte_t   reg0;
  logic    tx_en;
  byte_t   tx_data;
  logic    tx_busy;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) rst_sync <= 2'b00;
    else rst_sync <= {rst_sync[0], 1'b1};
  end

  assign rst_n_sync = rst_sync[1];

  uart_rx u_uart_rx (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_sync),
    .rx      (uart_rx),
    .rx_data (rx_data),
    .rx_wr   (rx_wr)
  );

  insn_loader u_insn_loader (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n_sync),
    .rx_wr      (rx_wr),
    .rx_data    (rx_data),
    .mem_wr     (mem_wr),
    .prog_ready (prog_ready),
    .recv_word  (recv_word)
  );

  // no reset, program survives a button press
  prog_mem u_prog_mem (
    .sys_clk (sys_clk),
    .mem_wr  (mem_wr),
    .pc      (pc),
    .insn    (insn)
  );

  cpu_core u_cpu_core (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n_sync),
    .prog_ready (prog_ready),
    .tx_busy    (tx_busy),
    .insn       (insn),
    .pc         (pc),
    .reg0       (reg0),
    .tx_en      (tx_en),
    .tx_data    (tx_data)
  );

  uart_tx u_uart_tx (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_sync),
    .tx_en   (tx_en),
    .tx_data (tx_data),
    .tx      (uart_tx),
    .tx_busy (tx_busy)
  );

  led_scan u_led_scan (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n_sync),
    .reg0      (reg0),
    .recv_word (recv_word),
    .led_col   (led_col),
    .led_row   (led_row)
  );

endmodule

// File: rtl/led_scan.sv
module led_scan import board_pkg::*, isa_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  byte_t      reg0,
  input  insn_t      recv_word,
  output byte_t      led_col,
  output logic [8:0] led_row
);

  scan_cnt_t cnt;  // position within the row period
  row_sel_t  row;
  logic      lit;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
      row <= '0;
    end else if (cnt == scan_cnt_t'(ROW_PERIOD - 1)) begin
      cnt <= '0;
      row <= row + 1'b1;  // 7 wraps to 0, row 8 unused
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // dark near both edges so neighbouring rows never overlap
  assign lit = cnt >= scan_cnt_t'(ROW_GAP) && cnt < scan_cnt_t'(ROW_PERIOD - ROW_GAP);

  assign led_row = lit ? 9'b1 << row : '0;

  always_comb begin
    case (row)
      3'd0:    led_col = 8'b10101010;       // alive marker
      3'd1:    led_col = reg0;
      3'd2:    led_col = recv_word[15:8];
      3'd3:    led_col = recv_word[7:0];
      default: led_col = '0;
    endcase
  end

endmodule

// File: rtl/cpu_core.sv
module cpu_core import board_pkg::*, isa_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst_n,
  input  logic  prog_ready,
  input  logic  tx_busy,
  input  insn_t insn,
  output pc_t   pc,
  output byte_t reg0,
  output logic  tx_en,
  output byte_t tx_data
);

  typedef enum logic [1:0] {IDLE, FETCH, EXEC, HALTED} state_e;

  state_e  state;
  opcode_e op;
  byte_t   imm;
  pc_t     pc_next;
  logic    out_go;  // OUT accepted this cycle

  assign op      = opcode_e'(insn[15:12]);
  assign imm     = insn[7:0];
  assign pc_next = pc + 1'b1;
  assign out_go  = prog_ready && state == EXEC && op == OUT && !tx_busy;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      pc    <= '0;
      reg0  <= '0;
      tx_en <= 1'b0;
    end else begin
      tx_en <= 1'b0;  // single cycle strobe
      if (!prog_ready) begin
        // loading, hold at reset vector
        state <= IDLE;
        pc    <= '0;
        reg0  <= '0;
      end else begin
        case (state)
          IDLE:  state <= FETCH;
          FETCH: state <= EXEC;  // ram read in flight
          EXEC: begin
            state <= FETCH;
            pc    <= pc_next;
            case (op)
              LDI:  reg0 <= imm;
              ADDI: reg0 <= reg0 + imm;  // wraps
              SUBI: reg0 <= reg0 - imm;
              OUT: begin
                if (out_go) begin
                  tx_en <= 1'b1;
                end else begin
                  // transmitter busy, retry same insn
                  state <= EXEC;
                  pc    <= pc;
                end
              end
              JMP: pc <= pc_t'(imm);
              JNZ: if (reg0 != '0) pc <= pc_t'(imm);
              HALT: begin
                state <= HALTED;
                pc    <= pc;
              end
              default: ;  // nop and unused codes
            endcase
          end
          HALTED: state <= HALTED;  // left only via prog_ready low
          default: state <= IDLE;
        endcase
      end
    end
  end

  // byte travels with tx_en
  always_ff @(posedge sys_clk) begin
    if (out_go) tx_data <= reg0;
  end

endmodule

// File: rtl/prog_mem.sv
module prog_mem import isa_pkg::*; (
  input  logic    sys_clk,
  input  mem_wr_t mem_wr,
  input  pc_t     pc,
  output insn_t   insn
);

  // 1024 x 16, maps onto block ram
  insn_t mem [2**$bits(pc_t)];

  // port a, write from loader
  always_ff @(posedge sys_clk) begin
    if (mem_wr.en) mem[mem_wr.addr] <= mem_wr.data;
  end

  // port b, cpu fetch, one cycle latency
  always_ff @(posedge sys_clk) begin
    insn <= mem[pc];
  end

endmodule

// File: rtl/insn_loader.sv
module insn_loader import board_pkg::*, isa_pkg::*; (
  input  logic    sys_clk,
  input  logic    rst_n,
  input  logic    rx_wr,
  input  byte_t   rx_data,
  output mem_wr_t mem_wr,
  output logic    prog_ready,
  output insn_t   recv_word
);

  logic phase;      // 0 waiting for high byte, 1 for low byte
  logic word_done;  // one cycle after low byte
  pc_t  addr;       // next free program address
  logic is_term;

  assign is_term = recv_word == TERM_WORD;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= 1'b0;
      word_done  <= 1'b0;
      addr       <= '0;
      prog_ready <= 1'b0;
      recv_word  <= '0;
    end else begin
      word_done <= rx_wr & phase;

      // last two bytes, high byte arrives first
      if (rx_wr) begin
        recv_word  <= {recv_word[7:0], rx_data};
        phase      <= ~phase;
        prog_ready <= 1'b0;  // any new byte starts a reload
      end

      if (word_done) begin
        if (is_term) begin
          prog_ready <= 1'b1;
          addr       <= '0;  // next program loads from 0
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end
  end

  // terminator itself is not stored
  assign mem_wr = '{en: word_done && !is_term, addr: addr, data: recv_word};

endmodule

// File: rtl/uart_tx.sv
module uart_tx import board_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst_n,
  input  logic  tx_en,
  input  byte_t tx_data,
  output logic  tx,
  output logic  tx_busy
);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

  state_e     state;
  baud_cnt_t  cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;  // remaining data bits
  logic       bit_end;

  assign bit_end = cnt == baud_cnt_t'(CLKS_PER_BIT - 1);
  assign tx_busy = state != IDLE;  // start through stop, 10 bits

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;  // idle mark
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (tx_en) begin
            tx    <= 1'b0;  // start bit next cycle
            state <= START;
          end
        end
        START: if (bit_end) begin
          tx      <= shreg[0];
          bit_idx <= '0;
          state   <= DATA;
        end
        DATA: if (bit_end) begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            tx    <= 1'b1;  // stop bit
            state <= STOP;
          end else begin
            tx <= shreg[0];
          end
        end
        STOP: if (bit_end) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // load on accept, shift as each bit goes out
  always_ff @(posedge sys_clk) begin
    if (state == IDLE && tx_en) shreg <= tx_data;
    else if ((state == START || state == DATA) && bit_end) shreg <= shreg >> 1;
  end

endmodule

// File: rtl/uart_rx.sv
module uart_rx import board_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst_n,
  input  logic  rx,
  output byte_t rx_data,
  output logic  rx_wr
);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

  state_e     state;
  logic [1:0] rx_sync;  // metastability flops
  baud_cnt_t  cnt;      // cycle within current bit
  logic [2:0] bit_idx;
  logic       rx_s;
  logic       half_end;
  logic       bit_end;

  assign rx_s     = rx_sync[1];
  assign half_end = cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1); // middle of start bit
  assign bit_end  = cnt == baud_cnt_t'(CLKS_PER_BIT - 1);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // line idles high
      state   <= IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      rx_wr   <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_wr   <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (!rx_s) state <= START;  // falling edge
        end
        START: if (half_end) begin
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rx_s ? IDLE : DATA;  // high again means a glitch, drop it
        end
        DATA: if (bit_end) begin
          cnt     <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= STOP;
        end
        STOP: if (bit_end) begin
          rx_wr <= rx_s;  // no strobe on a framing error
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // shift in lsb first, sampled mid bit
  always_ff @(posedge sys_clk) begin
    if (state == DATA && bit_end) rx_data <= {rx_s, rx_data[7:1]};
  end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

  // program memory is 1k words
  typedef logic [9:0] pc_t;

  // [15:12] opcode, [11:8] unused, [7:0] immediate
  typedef logic [15:0] insn_t;

  // undefined codes fall through as nop
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    LDI  = 4'd1,  // reg0 = imm
    ADDI = 4'd2,  // reg0 += imm, mod 256
    SUBI = 4'd3,  // reg0 -= imm, mod 256
    OUT  = 4'd4,  // send reg0 over uart
    JMP  = 4'd5,  // pc = imm
    JNZ  = 4'd6,  // pc = imm if reg0 != 0
    HALT = 4'd15
  } opcode_e;

  // end of program marker, never stored
  localparam insn_t TERM_WORD = 16'hFFFF;

  // loader -> program ram write port
  typedef struct packed {
    logic  en;
    pc_t   addr;
    insn_t data;
  } mem_wr_t;

endpackage

// File: rtl/board_pkg.sv
package board_pkg;

  // uart bit timing, in sys_clk cycles
  localparam int CLKS_PER_BIT = 16;

  // led matrix scan timing
  localparam int ROW_PERIOD = 27000; // cycles per row select
  localparam int ROW_GAP    = 500;   // dark cycles at both ends of a row

  // one uart character, also one led column pattern
  typedef logic [7:0] byte_t;

  // row index into the matrix, rows 0..7 used
  typedef logic [2:0] row_sel_t;

  // counts cycles within one uart bit
  typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

  // counts cycles within one led row period
  typedef logic [$clog2(ROW_PERIOD)-1:0] scan_cnt_t;

endpackage
